/* verilog.f */
morph_pkg.sv
bin_line_buffers.sv
morph_core.sv
morph_ctrl.sv
bin_morph_top.sv
tb_clock_gen.sv
bin_morph_assertions.sv
bin_morph_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bin_morph_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bin_morph_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module bin_morph_tb
    import morph_pkg::*;
();

    localparam int img_rows     = 8;
    localparam int frame_pixels = img_rows * line_width;
    localparam int frame_cycles = 4 + img_rows * (line_width + 2);
    localparam int max_cycles   = 8 * frame_cycles + 200;  // the tests take about 7.5 frames.

    logic      clk;
    logic      rstn;
    logic      bin;
    logic      de;
    logic      hsync;
    logic      cls;
    morph_op_t op;
    logic      out_bin;
    logic      out_valid;

    logic        img [0:1][0:img_rows-1][0:line_width-1];
    logic        exp_q[$];
    logic        got_q[$];
    logic [31:0] rng;
    int          bit_errors;
    int          op_errors;
    int          count_errors;
    int          cycle_count = 0;

    tb_clock_gen u_clk_gen (.clk(clk));

    bin_morph_top UUT (
        .clk      (clk),
        .rstn     (rstn),
        .bin      (bin),
        .de       (de),
        .hsync    (hsync),
        .cls      (cls),
        .op       (op),
        .out_bin  (out_bin),
        .out_valid(out_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected output for the window whose bottom right pixel is at row r, column c.
    function automatic logic model_pixel(int sel, int r, int c, morph_op_t mop);
        logic all_set;
        logic any_set;
        logic result;
        all_set = 1'b1;
        any_set = 1'b0;
        for (int dr = 0; dr < win_size; dr++) begin
            for (int dc = 0; dc < win_size; dc++) begin
                all_set = all_set & img[sel][r-dr][c-dc];
                any_set = any_set | img[sel][r-dr][c-dc];
            end
        end
        case (mop)
            op_erode:  result = all_set;
            op_dilate: result = any_set;
            default:   result = img[sel][r-2][c-2];
        endcase
        return result;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic fill_image(int sel, int density);
        for (int r = 0; r < img_rows; r++) begin
            for (int c = 0; c < line_width; c++) begin
                rng = xorshift32(rng);
                case (density)
                    1:       img[sel][r][c] = rng[0] | rng[1] | rng[2];  // seven in eight set.
                    2:       img[sel][r][c] = &rng[3:0];                // one in sixteen set.
                    default: img[sel][r][c] = rng[0];
                endcase
            end
        end
    endtask

    task automatic add_block(int sel, int r0, int c0);
        for (int r = 0; r <= win_size; r++) begin
            for (int c = 0; c <= win_size; c++) begin
                img[sel][r0+r][c0+c] = 1'b1;
            end
        end
    endtask

    task automatic start_frame(morph_op_t mop);
        next_cycle();
        cls = 1'b1;
        op  = mop;
        next_cycle();
        cls = 1'b0;
    endtask

    // raster order, with hsync and one idle cycle after each full line.
    task automatic send_pixels(int sel, int n_pix, morph_op_t mid_op);
        for (int idx = 0; idx < n_pix; idx++) begin
            next_cycle();
            de  = 1'b1;
            bin = img[sel][idx / line_width][idx % line_width];
            if (idx == (img_rows / 2) * line_width) begin
                op = mid_op;
            end
            if (idx % line_width == line_width - 1) begin
                next_cycle();
                de    = 1'b0;
                hsync = 1'b1;
                next_cycle();
                hsync = 1'b0;
            end
        end
        next_cycle();
        de = 1'b0;
    endtask

    task automatic expect_frame(int sel, morph_op_t mop, int n_pix);
        int r;
        int c;
        for (int idx = 0; idx < n_pix; idx++) begin
            r = idx / line_width;
            c = idx % line_width;
            if (r >= win_size - 1 && c >= win_size - 1) begin
                exp_q.push_back(model_pixel(sel, r, c, mop));
            end
        end
    endtask

    task automatic check_bit(string name, int idx, logic expected, logic actual);
        if (actual !== expected) begin
            bit_errors++;
            $display("** Error %s: pixel %0d expected %b, actual %b", name, idx, expected, actual);
        end
    endtask

    task automatic check_op(string name, morph_op_t expected, morph_op_t actual);
        if (actual !== expected) begin
            op_errors++;
            $display("** Error %s: op expected %s, actual %s", name, expected.name(),
                     actual.name());
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            count_errors++;
            $display("** Error %s: valid outputs expected %0d, actual %0d", name, expected,
                     actual);
        end
    endtask

    task automatic check_results(string name);
        int waited;
        waited = 0;
        repeat (3) next_cycle();  // covers the two cycle pipeline.
        while (got_q.size() < exp_q.size() && waited < 10) begin
            next_cycle();
            waited++;
        end
        check_count(name, exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_bit(name, i, exp_q[i], got_q[i]);
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic print_summary();
        $display("errors: pixel %0d, op %0d, count %0d, assertion %0d", bit_errors, op_errors,
                 count_errors, UUT.u_assertions.fail_count);
    endtask

    always @(negedge clk) begin
        if (rstn && out_valid) begin
            got_q.push_back(out_bin);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles.", max_cycles);
            print_summary();
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        rng          = 32'h82c7;
        bit_errors   = 0;
        op_errors    = 0;
        count_errors = 0;
        rstn  = 1'b0;
        bin   = 1'b0;
        de    = 1'b0;
        hsync = 1'b0;
        cls   = 1'b0;
        op    = op_pass;
        repeat (2) @(posedge clk);
        #5;
        rstn = 1'b1;

        // without a frame start the rows fill the window but stay invalid.
        check_op("reset_state", op_pass, UUT.u_ctrl.op_q);
        fill_image(0, 0);
        send_pixels(0, 6 * line_width, op_pass);
        check_results("reset_state");

        start_frame(op_pass);
        check_op("pass_frame", op_pass, UUT.u_ctrl.op_q);
        expect_frame(0, op_pass, frame_pixels);
        send_pixels(0, frame_pixels, op_pass);
        check_results("pass_frame");

        fill_image(0, 1);
        add_block(0, 1, 5);
        start_frame(op_erode);
        check_op("erode_frame", op_erode, UUT.u_ctrl.op_q);
        expect_frame(0, op_erode, frame_pixels);
        send_pixels(0, frame_pixels, op_erode);
        check_results("erode_frame");

        fill_image(0, 2);
        start_frame(op_dilate);
        check_op("dilate_frame", op_dilate, UUT.u_ctrl.op_q);
        expect_frame(0, op_dilate, frame_pixels);
        send_pixels(0, frame_pixels, op_dilate);
        check_results("dilate_frame");

        fill_image(0, 0);
        start_frame(op_pass);
        expect_frame(0, op_pass, frame_pixels);
        send_pixels(0, frame_pixels, op_dilate);
        check_op("op_latch", op_pass, UUT.u_ctrl.op_q);
        check_results("op_latch");
        fill_image(0, 2);
        start_frame(op);
        check_op("op_latch_next", op_dilate, UUT.u_ctrl.op_q);
        expect_frame(0, op_dilate, frame_pixels);
        send_pixels(0, frame_pixels, op_dilate);
        check_results("op_latch_next");

        // a dense first frame would show up as set bits if its lines leaked.
        fill_image(1, 1);
        fill_image(0, 2);
        start_frame(op_dilate);
        expect_frame(1, op_dilate, 5 * line_width + 7);
        send_pixels(1, 5 * line_width + 7, op_dilate);
        start_frame(op_dilate);
        expect_frame(0, op_dilate, frame_pixels);
        send_pixels(0, frame_pixels, op_dilate);
        check_results("back_to_back");

        print_summary();
        if (bit_errors + op_errors + count_errors + UUT.u_assertions.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : bin_morph_tb

`default_nettype wire

/* bin_morph_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module bin_morph_assertions (
    input logic clk      ,
    input logic rstn     ,
    input logic de       ,
    input logic hsync    ,
    input logic cls      ,
    input logic out_valid
);

    int reset_fails  = 0;
    int valid_fails  = 0;
    int strobe_fails = 0;
    int fail_count;

    assign fail_count = reset_fails + valid_fails + strobe_fails;

    a_reset_quiet: assert property (@(posedge clk) !rstn |-> !out_valid)
        else begin
            $error("out_valid is high while reset is asserted");
            reset_fails++;
        end

    // out_valid changes two edges after its pixel is taken, so it is sampled one edge later.
    a_valid_follows_de: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> $past(de, 3))
        else begin
            $error("out_valid is high without a pixel two cycles earlier");
            valid_fails++;
        end

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rstn)
        (hsync || cls) |-> !de)
        else begin
            $error("hsync or cls arrived together with de");
            strobe_fails++;
        end

endmodule : bin_morph_assertions

bind bin_morph_top bin_morph_assertions u_assertions (
    .clk      (clk),
    .rstn     (rstn),
    .de       (de),
    .hsync    (hsync),
    .cls      (cls),
    .out_valid(out_valid)
);

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam int period_ns = 100;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period_ns / 2) clk = ~clk;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* bin_morph_top.sv */
`default_nettype none
`timescale 1ns/1ps

module bin_morph_top
    import morph_pkg::*;
(
    input  logic      clk      ,
    input  logic      rstn     ,
    input  logic      bin      ,
    input  logic      de       ,
    input  logic      hsync    ,
    input  logic      cls      ,
    input  morph_op_t op       ,
    output logic      out_bin  ,
    output logic      out_valid
);

    logic [win_size-1:0] column;    // one pixel column of the window.
    logic                shift_en;
    morph_op_t           op_q;

    bin_line_buffers u_line_buffers (
        .clk   (clk),
        .rstn  (rstn),
        .bin   (bin),
        .de    (de),
        .hsync (hsync),
        .cls   (cls),
        .column(column)
    );

    morph_ctrl u_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .de       (de),
        .hsync    (hsync),
        .cls      (cls),
        .op       (op),
        .shift_en (shift_en),
        .op_q     (op_q),
        .out_valid(out_valid)
    );

    morph_core u_core (
        .clk     (clk),
        .rstn    (rstn),
        .column  (column),
        .shift_en(shift_en),
        .op_q    (op_q),
        .out_bin (out_bin)
    );

endmodule : bin_morph_top

`default_nettype wire

/* morph_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module morph_ctrl
    import morph_pkg::*;
(
    input  logic      clk      ,
    input  logic      rstn     ,
    input  logic      de       ,
    input  logic      hsync    ,
    input  logic      cls      ,
    input  morph_op_t op       ,
    output logic      shift_en ,
    output morph_op_t op_q     ,
    output logic      out_valid
);

    frame_state_t      state;
    logic [addr_w-1:0] col;
    logic [ptr_w-1:0]  row;         // saturates once the window is full height.
    logic              in_win;
    logic [1:0]        valid_pipe;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            op_q  <= op_pass;
        end else if (cls) begin
            state <= st_active;  // a start in an active frame restarts it.
            op_q  <= op;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col <= '0;
            row <= '0;
        end else if (cls) begin
            col <= '0;
            row <= '0;
        end else if (hsync) begin
            col <= '0;
            if (row != ptr_w'(win_size - 1)) begin
                row <= row + 1'b1;
            end
        end else if (de && col != addr_w'(line_width - 1)) begin
            col <= col + 1'b1;
        end
    end

    assign in_win = (state == st_active) && de && (row == ptr_w'(win_size - 1)) &&
                    (col >= addr_w'(win_size - 1));

    // shift_en meets the window one stage ahead of the registered result.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_en   <= 1'b0;
            valid_pipe <= '0;
            out_valid  <= 1'b0;
        end else begin
            shift_en   <= de;
            valid_pipe <= {valid_pipe[0], in_win};
            out_valid  <= valid_pipe[1];
        end
    end

endmodule : morph_ctrl

`default_nettype wire

/* morph_core.sv */
`default_nettype none
`timescale 1ns/1ps

module morph_core
    import morph_pkg::*;
(
    input  logic                clk     ,
    input  logic                rstn    ,
    input  logic [win_size-1:0] column  ,
    input  logic                shift_en,
    input  morph_op_t           op_q    ,
    output logic                out_bin
);

    // The window is stored as win_size columns of win_size bits each.
    // The newest column lives in the low bits, so bits [win_size-1:0]
    // hold column c and the top bits hold column c-4. Inside a column,
    // bit 0 is the oldest row, which keeps the centre at win_centre.
    logic [win_bits-1:0] win;
    logic                result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            win <= '0;
        end else if (shift_en) begin
            win <= {win[win_bits-win_size-1:0], column};  // oldest column drops out.
        end
    end

    always_comb begin
        case (op_q)
            op_pass: begin
                result = win[win_centre];
            end
            op_erode: begin
                result = &win;  // set only if every pixel in the window is set.
            end
            op_dilate: begin
                result = |win;  // set if any pixel in the window is set.
            end
            default: begin
                result = win[win_centre];
            end
        endcase
    end

    // out_bin is registered every cycle and only counts where out_valid is high.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_bin <= 1'b0;
        end else begin
            out_bin <= result;
        end
    end

endmodule : morph_core

`default_nettype wire

/* bin_line_buffers.sv */
`default_nettype none
`timescale 1ns/1ps

module bin_line_buffers
    import morph_pkg::*;
(
    input  logic                clk   ,
    input  logic                rstn  ,
    input  logic                bin   ,
    input  logic                de    ,
    input  logic                hsync ,
    input  logic                cls   ,
    output logic [win_size-1:0] column
);

    logic [addr_w-1:0]   addr;
    logic [ptr_w-1:0]    wr_ptr;   // memory that takes the current line.
    logic [win_size-1:0] rd_bits;  // registered reads, indexed by memory.
    logic                cur_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr   <= '0;
            wr_ptr <= '0;
        end else if (cls) begin
            addr   <= '0;
            wr_ptr <= '0;
        end else if (hsync) begin
            addr <= '0;
            if (wr_ptr == ptr_w'(win_size - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end else if (de && addr != addr_w'(line_width - 1)) begin
            addr <= addr + 1'b1;
        end
    end

    // one memory per line; the selected one is written while the rest are read.
    for (genvar i = 0; i < win_size; i++) begin : g_mem
        logic [line_width-1:0] mem;
        logic                  rd_q;

        always_ff @(posedge clk) begin
            if (de && wr_ptr == ptr_w'(i)) begin
                mem[addr] <= bin;
            end else begin
                rd_q <= mem[addr];
            end
        end

        assign rd_bits[i] = rd_q;
    end

    always_ff @(posedge clk) begin
        cur_q <= bin;
    end

    // the memory after the write pointer holds the oldest line.
    always_comb begin
        int sel;
        for (int k = 0; k < win_size - 1; k++) begin
            sel = int'(wr_ptr) + k + 1;
            if (sel >= win_size) begin
                sel = sel - win_size;
            end
            column[k] = rd_bits[sel];
        end
        column[win_size-1] = cur_q;  // newest row sits on top.
    end

endmodule : bin_line_buffers

`default_nettype wire

/* morph_pkg.sv */
`default_nettype none

package morph_pkg;

    // image and window geometry
    localparam int line_width = 16;  // pixels per line in this build.
    localparam int win_size   = 5;   // the window is win_size by win_size pixels.
    localparam int addr_w     = $clog2(line_width);
    localparam int ptr_w      = $clog2(win_size);  // also wide enough for a row count to four.
    localparam int win_bits   = win_size * win_size;
    localparam int win_centre = win_bits / 2;  // bit of the centre pixel in the flat window.

    typedef enum logic [1:0] {
        op_pass   = 2'd0,  // output is the window centre.
        op_erode  = 2'd1,  // output is the AND of the window.
        op_dilate = 2'd2   // output is the OR of the window.
    } morph_op_t;

    typedef enum logic {
        st_idle   = 1'b0,  // no frame start seen since reset.
        st_active = 1'b1
    } frame_state_t;

endpackage : morph_pkg

`default_nettype wire
